/* stream_bridge_top.f */
hdl/stream_bridge_pkg.sv
hdl/stream_fifo.sv
hdl/to_host_channel.sv
hdl/from_host_channel.sv
hdl/apb_host_regs.sv
hdl/stream_bridge_top.sv
dv/stream_bridge_tb.sv

/* Bender.yml */
package:
  name: stream_bridge

sources:
  - files:
      - hdl/stream_bridge_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/to_host_channel.sv
      - hdl/from_host_channel.sv
      - hdl/apb_host_regs.sv
      - hdl/stream_bridge_top.sv
  - target: test
    files:
      - dv/stream_bridge_tb.sv

/* dv/stream_bridge_tb.sv */
`timescale 1ns/1ps

module stream_bridge_tb
  import stream_bridge_pkg::*;
();

  localparam int DEPTH   = 16;
  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic ap_clk, rst_n, psel, penable, pwrite, pready, pslverr;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata, prdata;
  logic [WIDE_W-1:0] read_32_data, write_32_data;
  logic [NARROW_W-1:0] read_8_data, write_8_data;
  logic read_32_valid, read_32_ready, read_8_valid, read_8_ready;
  logic write_32_valid, write_32_ready, write_8_valid, write_8_ready;
  logic to_host_read_32_open, to_host_read_8_open;
  logic from_host_write_32_open, from_host_write_8_open;

  // Model state
  logic [WIDE_W-1:0]   q_rd32[$];
  logic [NARROW_W-1:0] q_rd8[$];
  logic [WIDE_W-1:0]   q_wr32[$];
  logic [NARROW_W-1:0] q_wr8[$];
  logic [3:0] ctrl_model;
  int errors = 0;
  int checks = 0;

  stream_bridge_top #(.DEPTH(DEPTH)) uut (.*);

  always #10 ap_clk = ~ap_clk;

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout: %s did not complete within %0d cycles", what, TIMEOUT);
  endtask

  function automatic logic [3:0] opens();
    return {from_host_write_8_open, from_host_write_32_open,
            to_host_read_8_open, to_host_read_32_open};
  endfunction

  function automatic logic [31:0] expected_status();
    logic [31:0] s;
    s = {28'd0, ctrl_model};
    s[4 + OPEN_RD32_BIT] = (q_rd32.size() != 0);
    s[4 + OPEN_RD8_BIT]  = (q_rd8.size() != 0);
    s[4 + OPEN_WR32_BIT] = (q_wr32.size() == DEPTH) || !ctrl_model[OPEN_WR32_BIT];
    s[4 + OPEN_WR8_BIT]  = (q_wr8.size() == DEPTH) || !ctrl_model[OPEN_WR8_BIT];
    return s;
  endfunction

  // Setup then access; returns at the edge that ends the access
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge ap_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge ap_clk);
    penable <= 1'b1;
    @(negedge ap_clk);
    while (!pready && n < TIMEOUT)
    begin
      @(negedge ap_clk);
      n++;
    end
    if (!pready)
      report_timeout("APB pready");
    rdata = prdata;
    err   = pslverr;
    @(posedge ap_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write_check(input string name, input logic [7:0] addr,
                                 input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic err;
    apb_access(1'b1, addr, data, rdata, err);
    check({name, " pslverr"}, exp_err, err);
  endtask

  task automatic apb_read_check(input string name, input logic [7:0] addr,
                                input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rdata;
    logic err;
    apb_access(1'b0, addr, '0, rdata, err);
    check({name, " prdata"}, exp_data, rdata);
    check({name, " pslverr"}, exp_err, err);
  endtask

  // Closing a channel empties its FIFO
  task automatic set_open(input logic [3:0] value);
    apb_write_check("open ctrl", REG_OPEN_CTRL, value, 1'b0);
    if (!value[OPEN_RD32_BIT]) q_rd32.delete();
    if (!value[OPEN_RD8_BIT])  q_rd8.delete();
    if (!value[OPEN_WR32_BIT]) q_wr32.delete();
    if (!value[OPEN_WR8_BIT])  q_wr8.delete();
    ctrl_model = value;
    repeat (OPEN_DELAY + 1) @(posedge ap_clk);
    @(negedge ap_clk);
    check("open flags", value, opens());
  endtask

  task automatic drain_write();
    int n;
    n = 0;
    while ((q_wr32.size() != 0 || q_wr8.size() != 0) && n < TIMEOUT)
    begin
      @(posedge ap_clk);
      write_32_ready <= $urandom % 2;
      write_8_ready  <= $urandom % 2;
      @(negedge ap_clk);
      check("wr32 valid", q_wr32.size() != 0, write_32_valid);
      check("wr8 valid", q_wr8.size() != 0, write_8_valid);
      if (q_wr32.size() != 0 && write_32_ready)
        check("wr32 data", q_wr32.pop_front(), write_32_data);
      if (q_wr8.size() != 0 && write_8_ready)
        check("wr8 data", q_wr8.pop_front(), write_8_data);
      n++;
    end
    if (q_wr32.size() != 0 || q_wr8.size() != 0)
      report_timeout("write stream drain");
    @(posedge ap_clk);
    write_32_ready <= 1'b0;
    write_8_ready  <= 1'b0;
    @(negedge ap_clk);
    check("wr streams idle", 2'b00, {write_32_valid, write_8_valid});
  endtask

  // Random beats until the model holds the target counts
  task automatic fill_read(input int t32, input int t8);
    int n;
    n = 0;
    while ((q_rd32.size() < t32 || q_rd8.size() < t8) && n < TIMEOUT)
    begin
      @(posedge ap_clk);
      read_32_valid <= (q_rd32.size() < t32) && ($urandom % 2);
      read_32_data  <= $urandom;
      read_8_valid  <= (q_rd8.size() < t8) && ($urandom % 2);
      read_8_data   <= $urandom;
      @(negedge ap_clk);
      check("rd32 ready", ctrl_model[OPEN_RD32_BIT] && q_rd32.size() < DEPTH, read_32_ready);
      check("rd8 ready", ctrl_model[OPEN_RD8_BIT] && q_rd8.size() < DEPTH, read_8_ready);
      if (read_32_valid && read_32_ready)
        q_rd32.push_back(read_32_data);
      if (read_8_valid && read_8_ready)
        q_rd8.push_back(read_8_data);
      n++;
    end
    if (q_rd32.size() < t32 || q_rd8.size() < t8)
      report_timeout("read stream fill");
    @(posedge ap_clk);
    read_32_valid <= 1'b0;
    read_8_valid  <= 1'b0;
  endtask

  task automatic drain_read();
    while (q_rd32.size() != 0)
      apb_read_check("rd32 pop", REG_RD32, q_rd32.pop_front(), 1'b0);
    while (q_rd8.size() != 0)
      apb_read_check("rd8 pop", REG_RD8, q_rd8.pop_front(), 1'b0);
    apb_read_check("rd32 empty", REG_RD32, '0, 1'b1);
    apb_read_check("rd8 empty", REG_RD8, '0, 1'b1);
  endtask

  initial
  begin
    logic [31:0] wval;
    logic [3:0]  prev_ctrl;
    ap_clk         = 0;
    rst_n          = 0;
    psel           = 0;
    penable        = 0;
    pwrite         = 0;
    paddr          = '0;
    pwdata         = '0;
    read_32_data   = '0;
    read_32_valid  = 0;
    read_8_data    = '0;
    read_8_valid   = 0;
    write_32_ready = 0;
    write_8_ready  = 0;
    ctrl_model     = '0;
    void'($urandom(67669));
    repeat (4) @(posedge ap_clk);
    rst_n <= 1'b1;

    // Reset state
    @(negedge ap_clk);
    check("reset opens", 4'h0, opens());
    check("reset valid", 2'b00, {write_32_valid, write_8_valid});
    check("reset ready", 2'b00, {read_32_ready, read_8_ready});
    apb_read_check("reset ctrl", REG_OPEN_CTRL, '0, 1'b0);

    // Open lag of exactly OPEN_DELAY cycles
    wval = $urandom;
    if (wval[3:0] == 4'h0)
      wval[3:0] = 4'hF;  // At least one flag has to move
    prev_ctrl = ctrl_model;
    apb_write_check("open write", REG_OPEN_CTRL, wval, 1'b0);
    ctrl_model = wval[3:0];
    repeat (OPEN_DELAY - 1) @(posedge ap_clk);
    @(negedge ap_clk);
    check("open before lag", prev_ctrl, opens());
    @(negedge ap_clk);
    check("open after lag", ctrl_model, opens());
    apb_read_check("open readback", REG_OPEN_CTRL, ctrl_model, 1'b0);

    // Host to application streams
    set_open(4'hF);
    repeat (10)
    begin
      wval = $urandom;
      apb_write_check("wr32 push", REG_WR32, wval, 1'b0);
      q_wr32.push_back(wval);
      wval = $urandom;
      apb_write_check("wr8 push", REG_WR8, wval, 1'b0);
      q_wr8.push_back(wval[7:0]);
    end
    apb_read_check("status wr", REG_STATUS, expected_status(), 1'b0);
    drain_write();

    // Application to host streams
    fill_read(12, 9);
    apb_read_check("status rd", REG_STATUS, expected_status(), 1'b0);
    drain_read();

    // Overflow and closed channel
    for (int i = 0; i <= DEPTH; i++)
    begin
      wval = $urandom;
      apb_write_check("wr8 fill", REG_WR8, wval, i == DEPTH);
      if (i < DEPTH)
        q_wr8.push_back(wval[7:0]);
    end
    apb_read_check("status full", REG_STATUS, expected_status(), 1'b0);
    drain_write();
    fill_read(DEPTH, 0);
    @(posedge ap_clk);
    read_32_valid <= 1'b1;
    @(negedge ap_clk);
    check("rd32 ready full", 1'b0, read_32_ready);
    @(posedge ap_clk);
    read_32_valid <= 1'b0;
    drain_read();
    set_open(4'hF & ~(4'h1 << OPEN_WR32_BIT));
    apb_write_check("wr32 closed", REG_WR32, $urandom, 1'b1);

    // Close and reopen flushes held data
    set_open(4'hF);
    repeat (3) apb_write_check("wr8 hold", REG_WR8, $urandom, 1'b0);
    fill_read(2, 0);
    @(negedge ap_clk);
    check("wr8 held valid", 1'b1, write_8_valid);
    set_open(4'hF & ~(4'h1 << OPEN_WR8_BIT) & ~(4'h1 << OPEN_RD32_BIT));
    set_open(4'hF);
    @(negedge ap_clk);
    check("wr8 valid reopen", 1'b0, write_8_valid);
    apb_read_check("rd32 reopen", REG_RD32, '0, 1'b1);
    apb_read_check("unmapped rd", 8'h18, '0, 1'b1);
    apb_write_check("unmapped wr", 8'h02, $urandom, 1'b1);
    apb_read_check("unmapped top", 8'hFC, '0, 1'b1);
    apb_write_check("status write", REG_STATUS, $urandom, 1'b1);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* hdl/stream_bridge_top.sv */
`timescale 1ns/1ps

module stream_bridge_top
  import stream_bridge_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic                  ap_clk,
  input  logic                  rst_n,
  // Host register access
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Application to host
  input  logic [WIDE_W-1:0]     read_32_data,
  input  logic                  read_32_valid,
  output logic                  read_32_ready,
  input  logic [NARROW_W-1:0]   read_8_data,
  input  logic                  read_8_valid,
  output logic                  read_8_ready,
  // Host to application
  output logic [WIDE_W-1:0]     write_32_data,
  output logic                  write_32_valid,
  input  logic                  write_32_ready,
  output logic [NARROW_W-1:0]   write_8_data,
  output logic                  write_8_valid,
  input  logic                  write_8_ready,
  output logic                  to_host_read_32_open,
  output logic                  to_host_read_8_open,
  output logic                  from_host_write_32_open,
  output logic                  from_host_write_8_open
);

  logic [3:0]          open_ctrl;
  logic [WIDE_W-1:0]   rd32_head;
  logic [NARROW_W-1:0] rd8_head;
  logic                rd32_not_empty;
  logic                rd8_not_empty;
  logic                rd32_pop;
  logic                rd8_pop;
  logic                wr32_full;
  logic                wr8_full;
  logic                wr32_push;
  logic                wr8_push;
  logic [WIDE_W-1:0]   wr32_data;
  logic [NARROW_W-1:0] wr8_data;

  apb_host_regs u_regs (
    .ap_clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .open_ctrl, .rd32_head, .rd8_head, .rd32_not_empty, .rd8_not_empty, .rd32_pop,
    .rd8_pop, .wr32_full, .wr8_full, .wr32_push, .wr8_push, .wr32_data, .wr8_data
  );

  to_host_channel #(.WIDTH(WIDE_W), .DEPTH(DEPTH)) u_read_32 (
    .ap_clk, .rst_n,
    .open_ctrl (open_ctrl[OPEN_RD32_BIT]),
    .in_data   (read_32_data),
    .in_valid  (read_32_valid),
    .in_ready  (read_32_ready),
    .pop       (rd32_pop),
    .head      (rd32_head),
    .not_empty (rd32_not_empty),
    .open      (to_host_read_32_open)
  );

  to_host_channel #(.WIDTH(NARROW_W), .DEPTH(DEPTH)) u_read_8 (
    .ap_clk, .rst_n,
    .open_ctrl (open_ctrl[OPEN_RD8_BIT]),
    .in_data   (read_8_data),
    .in_valid  (read_8_valid),
    .in_ready  (read_8_ready),
    .pop       (rd8_pop),
    .head      (rd8_head),
    .not_empty (rd8_not_empty),
    .open      (to_host_read_8_open)
  );

  from_host_channel #(.WIDTH(WIDE_W), .DEPTH(DEPTH)) u_write_32 (
    .ap_clk, .rst_n,
    .open_ctrl (open_ctrl[OPEN_WR32_BIT]),
    .push      (wr32_push),
    .push_data (wr32_data),
    .full      (wr32_full),
    .out_data  (write_32_data),
    .out_valid (write_32_valid),
    .out_ready (write_32_ready),
    .open      (from_host_write_32_open)
  );

  from_host_channel #(.WIDTH(NARROW_W), .DEPTH(DEPTH)) u_write_8 (
    .ap_clk, .rst_n,
    .open_ctrl (open_ctrl[OPEN_WR8_BIT]),
    .push      (wr8_push),
    .push_data (wr8_data),
    .full      (wr8_full),
    .out_data  (write_8_data),
    .out_valid (write_8_valid),
    .out_ready (write_8_ready),
    .open      (from_host_write_8_open)
  );

endmodule

/* hdl/apb_host_regs.sv */
`timescale 1ns/1ps

module apb_host_regs
  import stream_bridge_pkg::*;
(
  input  logic                  ap_clk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic [3:0]            open_ctrl,
  input  logic [WIDE_W-1:0]     rd32_head,
  input  logic [NARROW_W-1:0]   rd8_head,
  input  logic                  rd32_not_empty,
  input  logic                  rd8_not_empty,
  output logic                  rd32_pop,
  output logic                  rd8_pop,
  input  logic                  wr32_full,
  input  logic                  wr8_full,
  output logic                  wr32_push,
  output logic                  wr8_push,
  output logic [WIDE_W-1:0]     wr32_data,
  output logic [NARROW_W-1:0]   wr8_data
);

  localparam int FLAG_OFS = 4; // FIFO flags sit above the open bits

  reg_addr_e  addr;
  logic       apb_access;
  logic       open_wr;
  logic [7:0] status_bits;

  assign addr       = reg_addr_e'(paddr);
  assign apb_access = psel && penable;
  assign pready     = 1'b1;          // Zero wait states

  assign wr32_data = pwdata[WIDE_W-1:0];
  assign wr8_data  = pwdata[NARROW_W-1:0];  // Narrow channels use low byte

  assign status_bits[3:0]                      = open_ctrl;
  assign status_bits[FLAG_OFS + OPEN_RD32_BIT] = rd32_not_empty;
  assign status_bits[FLAG_OFS + OPEN_RD8_BIT]  = rd8_not_empty;
  assign status_bits[FLAG_OFS + OPEN_WR32_BIT] = wr32_full;
  assign status_bits[FLAG_OFS + OPEN_WR8_BIT]  = wr8_full;

  // Strobes fire in the access phase and act on the closing edge
  always_comb
  begin
    prdata    = '0;
    pslverr   = 1'b0;
    open_wr   = 1'b0;
    rd32_pop  = 1'b0;
    rd8_pop   = 1'b0;
    wr32_push = 1'b0;
    wr8_push  = 1'b0;
    if (apb_access)
    begin
      case (addr)
        REG_OPEN_CTRL:
        begin
          if (pwrite)
            open_wr = 1'b1;
          else
            prdata = APB_DATA_W'(open_ctrl);
        end
        REG_STATUS:
        begin
          if (pwrite)
            pslverr = 1'b1;  // Read only
          else
            prdata = APB_DATA_W'(status_bits);
        end
        REG_RD32:
        begin
          if (!pwrite)
          begin
            if (rd32_not_empty)
            begin
              prdata   = APB_DATA_W'(rd32_head);
              rd32_pop = 1'b1;
            end
            else
              pslverr = 1'b1;
          end
        end
        REG_RD8:
        begin
          if (!pwrite)
          begin
            if (rd8_not_empty)
            begin
              prdata  = APB_DATA_W'(rd8_head);
              rd8_pop = 1'b1;
            end
            else
              pslverr = 1'b1;
          end
        end
        REG_WR32:
        begin
          // Full or closed drops the word
          if (pwrite)
          begin
            if (wr32_full || !open_ctrl[OPEN_WR32_BIT])
              pslverr = 1'b1;
            else
              wr32_push = 1'b1;
          end
        end
        REG_WR8:
        begin
          if (pwrite)
          begin
            if (wr8_full || !open_ctrl[OPEN_WR8_BIT])
              pslverr = 1'b1;
            else
              wr8_push = 1'b1;
          end
        end
        default: pslverr = 1'b1;  // Unmapped
      endcase
    end
  end

  always_ff @(posedge ap_clk)
  begin
    if (!rst_n)
      open_ctrl <= '0;
    else if (open_wr)
      open_ctrl <= pwdata[3:0];
  end

endmodule

/* hdl/from_host_channel.sv */
`timescale 1ns/1ps

module from_host_channel
  import stream_bridge_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             ap_clk,
  input  logic             rst_n,
  input  logic             open_ctrl,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             full,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic             open
);

  logic                  fifo_empty;
  logic                  fifo_full;
  logic                  beat;
  logic [OPEN_DELAY-1:0] open_pipe;

  assign out_valid = !fifo_empty;
  assign beat      = out_valid && out_ready; // Pop on each transfer

  // A closed channel looks full to the host
  assign full = fifo_full || !open_ctrl;

  stream_fifo #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) u_fifo (
    .ap_clk    (ap_clk),
    .rst_n     (rst_n),
    .clear     (!open_ctrl),
    .push      (push),
    .pop       (beat),
    .push_data (push_data),
    .head      (out_data),   // Stable until taken
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  // Same open-flag delay as the to-host side
  always_ff @(posedge ap_clk)
  begin
    if (!rst_n)
      open_pipe <= '0;
    else
      open_pipe <= {open_pipe[OPEN_DELAY-2:0], open_ctrl};
  end

  assign open = open_pipe[OPEN_DELAY-1];

endmodule

/* hdl/to_host_channel.sv */
`timescale 1ns/1ps

module to_host_channel
  import stream_bridge_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             ap_clk,
  input  logic             rst_n,
  input  logic             open_ctrl,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             not_empty,
  output logic             open
);

  logic                  fifo_empty;
  logic                  fifo_full;
  logic                  beat;
  logic [OPEN_DELAY-1:0] open_pipe;

  // Only accept while the host has the channel open
  assign in_ready  = open_ctrl && !fifo_full;
  assign beat      = in_valid && in_ready;
  assign not_empty = !fifo_empty;

  stream_fifo #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) u_fifo (
    .ap_clk    (ap_clk),
    .rst_n     (rst_n),
    .clear     (!open_ctrl),  // Held empty while closed
    .push      (beat),
    .pop       (pop),
    .push_data (in_data),
    .head      (head),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  // Open flag lags the control bit by OPEN_DELAY cycles
  always_ff @(posedge ap_clk)
  begin
    if (!rst_n)
      open_pipe <= '0;
    else
      open_pipe <= {open_pipe[OPEN_DELAY-2:0], open_ctrl};
  end

  assign open = open_pipe[OPEN_DELAY-1];

endmodule

/* hdl/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             ap_clk,
  input  logic             rst_n,
  input  logic             clear,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] push_data,
  output logic [WIDTH-1:0] head,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap explicitly so any depth works
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign do_push = push && !full;  // Push while full is dropped
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign head    = mem[rd_ptr];    // Oldest word, first-word fall-through

  always_ff @(posedge ap_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge ap_clk)
  begin
    if (!rst_n || clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hdl/stream_bridge_pkg.sv */
package stream_bridge_pkg;

  // APB bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Channel data widths
  localparam int WIDE_W   = 32;
  localparam int NARROW_W = 8;

  // Register stages from control bit to application open flag
  localparam int OPEN_DELAY = 3;

  // Bit order in REG_OPEN_CTRL, repeated in both nibbles of REG_STATUS
  localparam int OPEN_RD32_BIT = 0;
  localparam int OPEN_RD8_BIT  = 1;
  localparam int OPEN_WR32_BIT = 2;
  localparam int OPEN_WR8_BIT  = 3;

  typedef enum logic [APB_ADDR_W-1:0] {
    REG_OPEN_CTRL = 8'h00, // Channel open bits, read/write
    REG_STATUS    = 8'h04, // Open bits plus FIFO flags, read only
    REG_RD32      = 8'h08, // Pop from wide to-host FIFO
    REG_RD8       = 8'h0C,
    REG_WR32      = 8'h10, // Push into wide from-host FIFO
    REG_WR8       = 8'h14
  } reg_addr_e;

endpackage
